//--- include/spu_config.svh
`ifndef SPU_CONFIG_SVH
`define SPU_CONFIG_SVH

// Register file geometry
`define SPU_REG_COUNT  128  // Architectural registers
`define SPU_REG_WIDTH  128  // Four 32-bit words per register
`define SPU_ADDR_WIDTH 7    // log2 of register count

// Control flow
`define SPU_PC_WIDTH   8    // Program counter bits

// Both pipes share one fixed depth, so latency is equal per slot
`define SPU_PIPE_DEPTH 4    // Stages from issue to writeback

`endif

//--- verilog/spu_isa_pkg.sv
package spu_isa_pkg;

	typedef enum logic [0:10] {
		OP_ADD    = 11'b00011000000,  // a  rt,ra,rb
		OP_AND    = 11'b00011000001,  // and
		OP_OR     = 11'b00001000001,  // or
		OP_XOR    = 11'b01001000001,  // xor
		OP_ADDI   = 11'b00011100000,  // ai, 8-bit opcode padded
		OP_MPY    = 11'b01111000100,  // mpy, signed 16x16
		OP_ROTQBY = 11'b00111011100,  // Quadword byte rotate
		OP_IL     = 11'b01000000100,  // Immediate load, 9-bit opcode padded
		OP_BR     = 11'b00110010000,  // Relative branch
		OP_BRZ    = 11'b00100000000,  // Branch if word 0 zero
		OP_NOP    = 11'b01000000001   // No operation
	} op_t;

	typedef enum logic [2:0] {FMT_RR, FMT_RRR, FMT_RI10, FMT_RI16, FMT_RI18} format_t;

	typedef enum logic [1:0] {
		UNIT_PERM = 2'd0,  // Odd slot permute
		UNIT_FX2  = 2'd1,  // Even slot
		UNIT_BR   = 2'd2,  // Odd slot branch
		UNIT_FX1  = 2'd3   // Even slot
	} unit_t;

	typedef logic [0:17] imm_t;  // Widest immediate field

	// First stage whose value can be forwarded, 0 when nothing is written
	function automatic logic [1:0] ready_stage(op_t op);
		case (op)
			OP_ADD, OP_ADDI, OP_AND, OP_OR, OP_XOR, OP_IL: ready_stage = 2'd1;
			OP_ROTQBY: ready_stage = 2'd2;  // Shuffle network
			OP_MPY:    ready_stage = 2'd3;  // Multiplier latency
			default:   ready_stage = 2'd0;  // Branches and nops
		endcase
	endfunction

endpackage

//--- verilog/spu_pipe_pkg.sv
`include "spu_config.svh"

package spu_pipe_pkg;

	typedef logic [0:`SPU_ADDR_WIDTH-1] addr_t;  // Register address
	typedef logic [0:`SPU_REG_WIDTH-1]  reg_t;   // Quadword, word 0 in bits 0..31

	typedef struct packed {
		logic       valid;      // Slot holds an instruction
		logic       reg_write;  // Result goes to rt
		addr_t      rt_addr;
		reg_t       value;
		logic [1:0] ready_at;   // Stage from which value is usable
		logic [2:0] stage;      // Current stage, 1 at issue
	} stage_entry_t;

	typedef struct packed {
		logic  reg_write;
		addr_t rt_addr;
		reg_t  value;
	} wb_t;

	// Index 0 is stage 1, the youngest
	typedef stage_entry_t [`SPU_PIPE_DEPTH-1:0] fw_bus_t;

	// Entry as it looks one stage further down
	function automatic stage_entry_t advance(stage_entry_t e);
		stage_entry_t next;
		next = e;
		next.stage = e.stage + 3'd1;
		return next;
	endfunction

endpackage

//--- verilog/spu_issue_if.sv
interface spu_issue_if import spu_isa_pkg::*, spu_pipe_pkg::*; ();

	logic     issue;      // Slot enters stage 1 at this edge
	op_t      op;
	format_t  format;
	unit_t    unit;
	addr_t    rt_addr;
	logic     reg_write;
	imm_t     imm;
	reg_t     ra;         // Operands after forwarding
	reg_t     rb;
	reg_t     rc_st;      // rc for even, rt store value for odd

	modport source (
		output issue, op, format, unit, rt_addr, reg_write, imm,
		output ra, rb, rc_st
	);

	modport sink (
		input issue, op, format, unit, rt_addr, reg_write, imm,
		input ra, rb, rc_st
	);

endinterface

//--- verilog/register_table.sv
`include "spu_config.svh"

module register_table import spu_pipe_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  addr_t ra_even_addr,
	input  addr_t rb_even_addr,
	input  addr_t rc_even_addr,
	input  addr_t ra_odd_addr,
	input  addr_t rb_odd_addr,
	input  addr_t rt_odd_addr,   // Store operand read through rt
	output reg_t  ra_even,
	output reg_t  rb_even,
	output reg_t  rc_even,
	output reg_t  ra_odd,
	output reg_t  rb_odd,
	output reg_t  rt_st_odd,
	input  wb_t   wb_even,
	input  wb_t   wb_odd
);

	reg_t regs [`SPU_REG_COUNT];  // Architectural state

	// Plain combinational reads, no write bypass
	assign ra_even   = regs[ra_even_addr];
	assign rb_even   = regs[rb_even_addr];
	assign rc_even   = regs[rc_even_addr];
	assign ra_odd    = regs[ra_odd_addr];
	assign rb_odd    = regs[rb_odd_addr];
	assign rt_st_odd = regs[rt_odd_addr];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `SPU_REG_COUNT; i++) begin
				regs[i] <= '0;  // Clean start
			end
		end else begin
			if (wb_even.reg_write)
				regs[wb_even.rt_addr] <= wb_even.value;
			if (wb_odd.reg_write)  // Slots never share rt
				regs[wb_odd.rt_addr] <= wb_odd.value;
		end
	end

endmodule

//--- verilog/operand_forward.sv
`include "spu_config.svh"

module operand_forward import spu_isa_pkg::*, spu_pipe_pkg::*; (
	input  op_t     op_even,
	input  format_t format_even,
	input  unit_t   unit_even,
	input  addr_t   rt_addr_even,
	input  logic    reg_write_even,
	input  imm_t    imm_even,
	input  addr_t   ra_even_addr,
	input  addr_t   rb_even_addr,
	input  addr_t   rc_even_addr,
	input  op_t     op_odd,
	input  format_t format_odd,
	input  unit_t   unit_odd,
	input  addr_t   rt_addr_odd,
	input  logic    reg_write_odd,
	input  imm_t    imm_odd,
	input  addr_t   ra_odd_addr,
	input  addr_t   rb_odd_addr,
	output addr_t   rf_ra_even_addr,  // Register table read ports
	output addr_t   rf_rb_even_addr,
	output addr_t   rf_rc_even_addr,
	output addr_t   rf_ra_odd_addr,
	output addr_t   rf_rb_odd_addr,
	output addr_t   rf_rt_odd_addr,
	input  reg_t    ra_even,
	input  reg_t    rb_even,
	input  reg_t    rc_even,
	input  reg_t    ra_odd,
	input  reg_t    rb_odd,
	input  reg_t    rt_st_odd,
	input  fw_bus_t fw_even,
	input  fw_bus_t fw_odd,
	output logic    stall_even_raw,
	output logic    stall_odd_raw,
	spu_issue_if.source even_slot,
	spu_issue_if.source odd_slot
);

	logic [2:0] haz_even, haz_odd;  // Per-source hazard flags, ra rb rc/rt

	// Youngest matching in-flight result wins over the table value
	function automatic logic resolve(input addr_t addr, input reg_t tbl, input fw_bus_t fe,
			input fw_bus_t fo, output reg_t value);
		logic hazard;
		value = tbl;
		hazard = 1'b0;
		for (int i = `SPU_PIPE_DEPTH - 1; i >= 0; i--) begin  // Oldest first
			if (fe[i].valid && fe[i].reg_write && fe[i].rt_addr == addr) begin
				value = fe[i].value;
				hazard = fe[i].ready_at > fe[i].stage;  // Not computed yet
			end
			if (fo[i].valid && fo[i].reg_write && fo[i].rt_addr == addr) begin
				value = fo[i].value;
				hazard = fo[i].ready_at > fo[i].stage;
			end
		end
		return hazard;
	endfunction

	assign rf_ra_even_addr = ra_even_addr;
	assign rf_rb_even_addr = rb_even_addr;
	assign rf_rc_even_addr = rc_even_addr;
	assign rf_ra_odd_addr  = ra_odd_addr;
	assign rf_rb_odd_addr  = rb_odd_addr;
	assign rf_rt_odd_addr  = rt_addr_odd;  // Store value lives in rt

	always_comb begin
		haz_even[0] = resolve(ra_even_addr, ra_even, fw_even, fw_odd, even_slot.ra);
		haz_even[1] = resolve(rb_even_addr, rb_even, fw_even, fw_odd, even_slot.rb);
		haz_even[2] = resolve(rc_even_addr, rc_even, fw_even, fw_odd, even_slot.rc_st);
		haz_odd[0]  = resolve(ra_odd_addr, ra_odd, fw_even, fw_odd, odd_slot.ra);
		haz_odd[1]  = resolve(rb_odd_addr, rb_odd, fw_even, fw_odd, odd_slot.rb);
		haz_odd[2]  = resolve(rt_addr_odd, rt_st_odd, fw_even, fw_odd, odd_slot.rc_st);
	end

	assign stall_even_raw = |haz_even;
	assign stall_odd_raw  = |haz_odd;

	// Pair issues together or not at all
	assign even_slot.issue = !(stall_even_raw || stall_odd_raw);
	assign odd_slot.issue  = !(stall_even_raw || stall_odd_raw);

	assign even_slot.op        = op_even;
	assign even_slot.format    = format_even;
	assign even_slot.unit      = unit_even;
	assign even_slot.rt_addr   = rt_addr_even;
	assign even_slot.reg_write = reg_write_even;
	assign even_slot.imm       = imm_even;
	assign odd_slot.op         = op_odd;
	assign odd_slot.format     = format_odd;
	assign odd_slot.unit       = unit_odd;
	assign odd_slot.rt_addr    = rt_addr_odd;
	assign odd_slot.reg_write  = reg_write_odd;
	assign odd_slot.imm        = imm_odd;

endmodule

//--- verilog/even_pipe.sv
`include "spu_config.svh"

module even_pipe import spu_isa_pkg::*, spu_pipe_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	spu_issue_if.sink slot,
	input  logic    branch_kill,  // Odd branch first in pair
	output fw_bus_t fw_bus,
	output wb_t     wb
);

	fw_bus_t      stages;    // Result shift register, [0] is stage 1
	stage_entry_t entry_in;  // What enters stage 1
	reg_t         rb_eff;    // rb or replicated immediate
	reg_t         result;
	logic [0:31]  imm10_word;
	logic         even_unit;

	assign imm10_word = {{22{slot.imm[8]}}, slot.imm[8:17]};  // Low 10 bits, sign extended
	assign rb_eff     = (slot.format == FMT_RI10) ? {4{imm10_word}} : slot.rb;
	assign even_unit  = (slot.unit == UNIT_FX1) || (slot.unit == UNIT_FX2);

	always_comb begin
		result = '0;
		case (slot.op)
			OP_ADD, OP_ADDI: begin
				for (int w = 0; w < 4; w++) begin
					result[32*w +: 32] = slot.ra[32*w +: 32] + rb_eff[32*w +: 32];  // Per word
				end
			end
			OP_AND: result = slot.ra & rb_eff;
			OP_OR:  result = slot.ra | rb_eff;
			OP_XOR: result = slot.ra ^ rb_eff;
			OP_MPY: begin
				for (int w = 0; w < 4; w++) begin
					result[32*w +: 32] = $signed(slot.ra[32*w+16 +: 16])
						* $signed(slot.rb[32*w+16 +: 16]);  // Low halfwords, signed
				end
			end
			default: result = '0;
		endcase
	end

	always_comb begin
		entry_in.valid     = slot.issue && !branch_kill;  // Killed twin becomes a bubble
		entry_in.reg_write = entry_in.valid && slot.reg_write && even_unit
			&& (ready_stage(slot.op) != 2'd0);
		entry_in.rt_addr   = slot.rt_addr;
		entry_in.value     = result;                // MPY value early, held back by ready_at
		entry_in.ready_at  = ready_stage(slot.op);
		entry_in.stage     = 3'd1;
	end

	always_ff @(posedge clk) begin
		stages[0] <= entry_in;
		for (int i = 1; i < `SPU_PIPE_DEPTH; i++) begin
			stages[i] <= advance(stages[i-1]);
		end
		if (reset) begin
			for (int i = 0; i < `SPU_PIPE_DEPTH; i++) begin
				stages[i].valid     <= 1'b0;  // Payload left as is
				stages[i].reg_write <= 1'b0;
			end
		end
	end

	assign fw_bus = stages;

	// Last stage writes the table at the next edge
	assign wb.reg_write = stages[`SPU_PIPE_DEPTH-1].valid && stages[`SPU_PIPE_DEPTH-1].reg_write;
	assign wb.rt_addr   = stages[`SPU_PIPE_DEPTH-1].rt_addr;
	assign wb.value     = stages[`SPU_PIPE_DEPTH-1].value;

endmodule

//--- verilog/odd_pipe.sv
`include "spu_config.svh"

module odd_pipe import spu_isa_pkg::*, spu_pipe_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	spu_issue_if.sink                slot,
	input  logic [`SPU_PC_WIDTH-1:0] pc,
	input  logic                     first_odd,    // Odd instruction is older in the pair
	output logic                     branch_kill,
	output logic [`SPU_PC_WIDTH-1:0] pc_wb,
	output logic                     branch_taken,
	output fw_bus_t                  fw_bus,
	output wb_t                      wb
);

	fw_bus_t      stages;
	stage_entry_t entry_in;
	reg_t         result;
	logic [3:0]   rot_bytes;     // Byte count from word 0 of rb
	logic [7:0]   rot_bits;
	logic [0:31]  imm16_word;
	logic         taken;         // Branch resolves taken this issue

	assign rot_bytes  = slot.rb[28:31];
	assign rot_bits   = {1'b0, rot_bytes, 3'b000};
	assign imm16_word = {{16{slot.imm[2]}}, slot.imm[2:17]};

	always_comb begin
		case (slot.op)
			OP_ROTQBY: result = (slot.ra << rot_bits)
				| (slot.ra >> (8'd128 - rot_bits));  // Byte 0 takes byte n
			OP_IL:     result = {4{imm16_word}};
			default:   result = '0;
		endcase
	end

	// Conditions checked on the forwarded rt value
	always_comb begin
		taken = 1'b0;
		if (slot.issue && slot.unit == UNIT_BR) begin
			if (slot.op == OP_BR)
				taken = 1'b1;
			else if (slot.op == OP_BRZ)
				taken = (slot.rc_st[0:31] == 32'd0);
		end
	end

	assign branch_kill = taken && first_odd;  // Even twin is younger

	always_ff @(posedge clk) begin
		if (reset)
			branch_taken <= 1'b0;
		else
			branch_taken <= taken;              // One cycle pulse
		pc_wb <= pc + slot.imm[10:17];          // Signed 8-bit offset wraps in PC width
	end

	always_comb begin
		entry_in.valid     = slot.issue;
		entry_in.reg_write = slot.issue && slot.reg_write && (ready_stage(slot.op) != 2'd0);
		entry_in.rt_addr   = slot.rt_addr;
		entry_in.value     = result;
		entry_in.ready_at  = ready_stage(slot.op);  // Rotate held one more stage
		entry_in.stage     = 3'd1;
	end

	always_ff @(posedge clk) begin
		stages[0] <= entry_in;
		for (int i = 1; i < `SPU_PIPE_DEPTH; i++) begin
			stages[i] <= advance(stages[i-1]);
		end
		if (reset) begin
			for (int i = 0; i < `SPU_PIPE_DEPTH; i++) begin
				stages[i].valid     <= 1'b0;
				stages[i].reg_write <= 1'b0;
			end
		end
	end

	assign fw_bus = stages;

	assign wb.reg_write = stages[`SPU_PIPE_DEPTH-1].valid && stages[`SPU_PIPE_DEPTH-1].reg_write;
	assign wb.rt_addr   = stages[`SPU_PIPE_DEPTH-1].rt_addr;
	assign wb.value     = stages[`SPU_PIPE_DEPTH-1].value;

endmodule

//--- verilog/spu_pipes.sv
`include "spu_config.svh"

module spu_pipes import spu_isa_pkg::*, spu_pipe_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  logic [`SPU_PC_WIDTH-1:0] pc,
	input  logic                     first_odd,
	input  op_t                      op_even,
	input  format_t                  format_even,
	input  unit_t                    unit_even,
	input  addr_t                    rt_addr_even,
	input  logic                     reg_write_even,
	input  imm_t                     imm_even,
	input  addr_t                    ra_even_addr,
	input  addr_t                    rb_even_addr,
	input  addr_t                    rc_even_addr,
	input  op_t                      op_odd,
	input  format_t                  format_odd,
	input  unit_t                    unit_odd,
	input  addr_t                    rt_addr_odd,
	input  logic                     reg_write_odd,
	input  imm_t                     imm_odd,
	input  addr_t                    ra_odd_addr,
	input  addr_t                    rb_odd_addr,
	output logic                     stall_even_raw,  // Hold the pair while high
	output logic                     stall_odd_raw,
	output logic [`SPU_PC_WIDTH-1:0] pc_wb,
	output logic                     branch_taken,
	output logic                     wb_even_valid,
	output addr_t                    wb_even_addr,
	output reg_t                     wb_even_data,
	output logic                     wb_odd_valid,
	output addr_t                    wb_odd_addr,
	output reg_t                     wb_odd_data
);

	addr_t   rf_ra_even_addr, rf_rb_even_addr, rf_rc_even_addr;
	addr_t   rf_ra_odd_addr, rf_rb_odd_addr, rf_rt_odd_addr;
	reg_t    ra_even, rb_even, rc_even, ra_odd, rb_odd, rt_st_odd;  // Table read data
	fw_bus_t fw_even, fw_odd;    // In-flight results
	wb_t     wb_even, wb_odd;
	logic    branch_kill;        // Odd to even twin suppression

	spu_issue_if even_slot_if ();
	spu_issue_if odd_slot_if ();

	register_table register_table_inst (
		.clk(clk), .reset(reset),
		.ra_even_addr(rf_ra_even_addr), .rb_even_addr(rf_rb_even_addr),
		.rc_even_addr(rf_rc_even_addr), .ra_odd_addr(rf_ra_odd_addr),
		.rb_odd_addr(rf_rb_odd_addr), .rt_odd_addr(rf_rt_odd_addr),
		.ra_even(ra_even), .rb_even(rb_even), .rc_even(rc_even),
		.ra_odd(ra_odd), .rb_odd(rb_odd), .rt_st_odd(rt_st_odd),
		.wb_even(wb_even), .wb_odd(wb_odd)
	);

	operand_forward operand_forward_inst (
		.op_even(op_even), .format_even(format_even), .unit_even(unit_even),
		.rt_addr_even(rt_addr_even), .reg_write_even(reg_write_even), .imm_even(imm_even),
		.ra_even_addr(ra_even_addr), .rb_even_addr(rb_even_addr), .rc_even_addr(rc_even_addr),
		.op_odd(op_odd), .format_odd(format_odd), .unit_odd(unit_odd),
		.rt_addr_odd(rt_addr_odd), .reg_write_odd(reg_write_odd), .imm_odd(imm_odd),
		.ra_odd_addr(ra_odd_addr), .rb_odd_addr(rb_odd_addr),
		.rf_ra_even_addr(rf_ra_even_addr), .rf_rb_even_addr(rf_rb_even_addr),
		.rf_rc_even_addr(rf_rc_even_addr), .rf_ra_odd_addr(rf_ra_odd_addr),
		.rf_rb_odd_addr(rf_rb_odd_addr), .rf_rt_odd_addr(rf_rt_odd_addr),
		.ra_even(ra_even), .rb_even(rb_even), .rc_even(rc_even),
		.ra_odd(ra_odd), .rb_odd(rb_odd), .rt_st_odd(rt_st_odd),
		.fw_even(fw_even), .fw_odd(fw_odd),
		.stall_even_raw(stall_even_raw), .stall_odd_raw(stall_odd_raw),
		.even_slot(even_slot_if.source), .odd_slot(odd_slot_if.source)
	);

	even_pipe even_pipe_inst (
		.clk(clk), .reset(reset), .slot(even_slot_if.sink),
		.branch_kill(branch_kill), .fw_bus(fw_even), .wb(wb_even)
	);

	odd_pipe odd_pipe_inst (
		.clk(clk), .reset(reset), .slot(odd_slot_if.sink),
		.pc(pc), .first_odd(first_odd), .branch_kill(branch_kill),
		.pc_wb(pc_wb), .branch_taken(branch_taken), .fw_bus(fw_odd), .wb(wb_odd)
	);

	// Writeback records split onto flat ports
	assign wb_even_valid = wb_even.reg_write;
	assign wb_even_addr  = wb_even.rt_addr;
	assign wb_even_data  = wb_even.value;
	assign wb_odd_valid  = wb_odd.reg_write;
	assign wb_odd_addr   = wb_odd.rt_addr;
	assign wb_odd_data   = wb_odd.value;

endmodule

//--- tests/spu_pipes_props.sv
module spu_pipes_props (
	input logic clk,
	input logic reset,
	input logic stall_even_raw,
	input logic stall_odd_raw,
	input logic wb_even_valid,
	input logic wb_odd_valid,
	input logic branch_taken
);

	int assert_errors = 0;  // Failed assertion count

	// One edge into reset everything is quiet
	reset_quiet: assert property (@(posedge clk) reset |=> !stall_even_raw && !stall_odd_raw
		&& !wb_even_valid && !wb_odd_valid && !branch_taken)
		else begin
			$error("Outputs not cleared after reset");
			assert_errors++;
		end

	// Held pair leaves a bubble that reaches writeback four edges later
	stall_bubble: assert property (@(posedge clk) disable iff (reset)
		(stall_even_raw || stall_odd_raw) |-> ##4 (!wb_even_valid && !wb_odd_valid))
		else begin
			$error("Writeback seen for a stalled pair");
			assert_errors++;
		end

	branch_after_issue: assert property (@(posedge clk) disable iff (reset)
		branch_taken |-> $past(!stall_even_raw && !stall_odd_raw))  // Only issued pairs branch
		else begin
			$error("Branch taken without an issued pair");
			assert_errors++;
		end

endmodule

//--- tests/spu_pipes_checker.sv
`include "spu_config.svh"

module spu_pipes_checker import spu_isa_pkg::*, spu_pipe_pkg::*; (
	input  logic                     clk, reset, first_odd,
	input  logic [`SPU_PC_WIDTH-1:0] pc, pc_wb,
	input  op_t                      op_even, op_odd,
	input  addr_t                    rt_addr_even, ra_even_addr, rb_even_addr, rc_even_addr,
	input  addr_t                    rt_addr_odd, ra_odd_addr, rb_odd_addr,
	input  imm_t                     imm_even, imm_odd,
	input  logic                     stall_even_raw, stall_odd_raw, branch_taken,
	input  logic                     wb_even_valid, wb_odd_valid,
	input  addr_t                    wb_even_addr, wb_odd_addr,
	input  reg_t                     wb_even_data, wb_odd_data,
	output int                       error_count, check_count, kill_count
);

	typedef struct {
		logic                     ev_valid, od_valid, taken;
		addr_t                    ev_addr, od_addr;
		logic [127:0]             ev_data, od_data;
		logic [`SPU_PC_WIDTH-1:0] pc;
	} expect_t;

	logic [127:0] model [`SPU_REG_COUNT];  // Architectural registers, word 0 on top
	expect_t      ring [8];                // Expected outputs, indexed by cycle
	int           cyc;
	addr_t        fl_addr [2][4];          // In-flight destinations, [slot][0] is stage 1
	int           fl_ready [2][4];         // Stage a result forwards from, 0 for no write

	function automatic logic [31:0] word_of(logic [127:0] q, int w);
		return q[127-32*w -: 32];
	endfunction

	// Youngest in-flight writer decides whether a source has to wait
	function automatic logic pending(addr_t a);
		for (int i = 0; i < 4; i++) begin
			for (int s = 0; s < 2; s++) begin
				if (fl_ready[s][i] != 0 && fl_addr[s][i] == a)
					return fl_ready[s][i] > i + 1;
			end
		end
		return 1'b0;
	endfunction

	function automatic logic [127:0] even_result(op_t op, logic [127:0] a, logic [127:0] b,
			logic [17:0] ie);
		logic [127:0] r;
		logic [31:0]  x, y;
		r = '0;
		for (int w = 0; w < 4; w++) begin
			x = word_of(a, w);
			y = word_of(b, w);
			case (op)
				OP_ADD:  r[127-32*w -: 32] = x + y;
				OP_ADDI: r[127-32*w -: 32] = x + {{22{ie[9]}}, ie[9:0]};
				OP_AND:  r[127-32*w -: 32] = x & y;
				OP_OR:   r[127-32*w -: 32] = x | y;
				OP_XOR:  r[127-32*w -: 32] = x ^ y;
				OP_MPY:  r[127-32*w -: 32] = {{16{x[15]}}, x[15:0]} * {{16{y[15]}}, y[15:0]};
				default: r[127-32*w -: 32] = '0;
			endcase
		end
		return r;
	endfunction

	// Byte 0 is the most significant and takes byte n
	function automatic logic [127:0] rotate_bytes(logic [127:0] a, int n);
		logic [127:0] r;
		for (int i = 0; i < 16; i++)
			r[127-8*i -: 8] = a[127-8*((i + n) % 16) -: 8];
		return r;
	endfunction

	task automatic compare_wb(string name, logic ev, addr_t ea, logic [127:0] ed,
			logic v, addr_t a, reg_t d);
		check_count++;
		if (v !== ev || (ev && (a !== ea || d !== ed))) begin
			error_count++;
			$display("Fail %0t: %s writeback valid %0b addr %0d data %h, expected %0b %0d %h",
				$time, name, v, a, d, ev, ea, ed);
		end
	endtask

	always @(negedge clk) begin
		expect_t      e;
		logic [127:0] ra_e, rb_e, ra_o, rb_o, st_o;
		logic [31:0]  w0, il_word;
		logic [17:0]  ie, io;
		logic         taken, kill;
		logic         exp_se, exp_so;
		if (reset) begin
			foreach (model[i]) model[i] = '0;
			foreach (ring[i]) ring[i] = '{default: '0};
			for (int s = 0; s < 2; s++) begin
				for (int i = 0; i < 4; i++)
					fl_ready[s][i] = 0;  // Nothing in flight
			end
			cyc = 0;
			error_count = 0;
			check_count = 0;
			kill_count = 0;
		end else begin
			e = ring[cyc % 8];
			compare_wb("even", e.ev_valid, e.ev_addr, e.ev_data, wb_even_valid, wb_even_addr,
				wb_even_data);
			compare_wb("odd", e.od_valid, e.od_addr, e.od_data, wb_odd_valid, wb_odd_addr,
				wb_odd_data);
			check_count++;
			if (branch_taken !== e.taken || (e.taken && pc_wb !== e.pc)) begin
				error_count++;
				$display("Fail %0t: branch_taken %0b pc_wb %0d, expected %0b %0d", $time,
					branch_taken, pc_wb, e.taken, e.pc);
			end
			exp_se = pending(ra_even_addr) || pending(rb_even_addr) || pending(rc_even_addr);
			exp_so = pending(ra_odd_addr) || pending(rb_odd_addr) || pending(rt_addr_odd);
			check_count++;
			if (stall_even_raw !== exp_se || stall_odd_raw !== exp_so) begin
				error_count++;
				$display("Fail %0t: stall even %0b odd %0b, expected %0b %0b", $time,
					stall_even_raw, stall_odd_raw, exp_se, exp_so);
			end
			for (int s = 0; s < 2; s++) begin  // Everything moves one stage at the edge
				for (int i = 3; i > 0; i--) begin
					fl_addr[s][i] = fl_addr[s][i-1];
					fl_ready[s][i] = fl_ready[s][i-1];
				end
				fl_ready[s][0] = 0;  // Bubble unless the pair issues
			end
			ring[cyc % 8] = '{default: '0};
			if (!stall_even_raw && !stall_odd_raw) begin  // Pair issues at the next edge
				ra_e = model[ra_even_addr];                 // Both slots read the old state
				rb_e = model[rb_even_addr];
				ra_o = model[ra_odd_addr];
				rb_o = model[rb_odd_addr];
				st_o = model[rt_addr_odd];
				ie = imm_even;
				io = imm_odd;
				il_word = {{16{io[15]}}, io[15:0]};
				w0 = word_of(rb_o, 0);
				taken = (op_odd == OP_BR) || (op_odd == OP_BRZ && word_of(st_o, 0) == 32'd0);
				kill = taken && first_odd;               // Older branch removes the twin
				ring[(cyc + 1) % 8].taken = taken;
				ring[(cyc + 1) % 8].pc = pc + io[7:0];
				ring[(cyc + 4) % 8].ev_valid = !kill
					&& (op_even inside {OP_ADD, OP_ADDI, OP_AND, OP_OR, OP_XOR, OP_MPY});
				ring[(cyc + 4) % 8].ev_addr = rt_addr_even;
				ring[(cyc + 4) % 8].ev_data = even_result(op_even, ra_e, rb_e, ie);
				ring[(cyc + 4) % 8].od_valid = op_odd inside {OP_ROTQBY, OP_IL};
				ring[(cyc + 4) % 8].od_addr = rt_addr_odd;
				ring[(cyc + 4) % 8].od_data = (op_odd == OP_IL) ? {4{il_word}}
					: rotate_bytes(ra_o, w0[3:0]);
				if (ring[(cyc + 4) % 8].ev_valid) begin
					model[rt_addr_even] = ring[(cyc + 4) % 8].ev_data;
					fl_addr[0][0] = rt_addr_even;
					fl_ready[0][0] = (op_even == OP_MPY) ? 3 : 1;  // Multiplier latency
				end
				if (ring[(cyc + 4) % 8].od_valid) begin
					model[rt_addr_odd] = ring[(cyc + 4) % 8].od_data;
					fl_addr[1][0] = rt_addr_odd;
					fl_ready[1][0] = (op_odd == OP_ROTQBY) ? 2 : 1;  // Shuffle takes a stage
				end
				if (kill)
					kill_count++;
			end
			cyc++;
		end
	end

endmodule

//--- tests/spu_pipes_tb.sv
`include "spu_config.svh"

module spu_pipes_tb import spu_isa_pkg::*, spu_pipe_pkg::*; ();

	localparam int PAIRS = 424;  // 8 fills, 400 random, 8 readbacks, 8 drain

	logic                     clk, reset, first_odd;
	logic [`SPU_PC_WIDTH-1:0] pc, pc_wb;
	op_t                      op_even, op_odd;
	format_t                  format_even, format_odd;
	unit_t                    unit_even, unit_odd;
	addr_t                    rt_addr_even, ra_even_addr, rb_even_addr, rc_even_addr;
	addr_t                    rt_addr_odd, ra_odd_addr, rb_odd_addr;
	logic                     reg_write_even, reg_write_odd;
	imm_t                     imm_even, imm_odd;
	logic                     stall_even_raw, stall_odd_raw, branch_taken;
	logic                     wb_even_valid, wb_odd_valid;
	addr_t                    wb_even_addr, wb_odd_addr;
	reg_t                     wb_even_data, wb_odd_data;
	int                       error_count, check_count, kill_count;  // From the checker
	int                       stall_cycles, total_errors;
	int                       taken_count = 0;
	int                       tb_errors = 0;
	logic [31:0]              lfsr_state;
	string                    summary;

	spu_pipes spu_pipes_inst (.*);
	spu_pipes_checker checker_inst (.*);
	bind spu_pipes spu_pipes_props props_inst (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic next_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];  // x^32+x^22+x^2+x+1
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] draw(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], next_bit()};
		return v;
	endfunction

	// Eight registers only, so hazards come often
	function automatic addr_t pool_addr(logic [2:0] idx);
		return {idx, 4'd5};
	endfunction

	task automatic hold_until_issued();
		@(negedge clk);
		while (stall_even_raw || stall_odd_raw) begin  // Same pair stays on the inputs
			stall_cycles++;
			@(negedge clk);
		end
	endtask

	task automatic drive_pair(op_t oe, addr_t rte, addr_t rae, addr_t rbe,
			op_t oo, addr_t rto, addr_t rao, addr_t rbo);
		@(posedge clk);
		#1;
		op_even = oe;
		format_even = (oe == OP_ADDI) ? FMT_RI10 : FMT_RR;
		unit_even = draw(1) ? UNIT_FX1 : UNIT_FX2;
		rt_addr_even = rte;
		ra_even_addr = rae;
		rb_even_addr = rbe;
		rc_even_addr = pool_addr(3'(draw(3)));
		reg_write_even = (oe != OP_NOP);
		imm_even = 18'(draw(18));
		op_odd = oo;
		format_odd = (oo inside {OP_IL, OP_BR, OP_BRZ}) ? FMT_RI16 : FMT_RR;
		unit_odd = (oo inside {OP_BR, OP_BRZ}) ? UNIT_BR : UNIT_PERM;
		rt_addr_odd = rto;
		ra_odd_addr = rao;
		rb_odd_addr = rbo;
		reg_write_odd = (oo inside {OP_ROTQBY, OP_IL});
		imm_odd = 18'(draw(18));
		pc = 8'(draw(8));
		first_odd = draw(1);
		hold_until_issued();
	endtask

	task automatic random_pair();
		op_t   oe, oo;
		addr_t rte, rto, rao, rbo;
		case (3'(draw(3)))
			3'd0: oe = OP_ADD;
			3'd1: oe = OP_AND;
			3'd2: oe = OP_OR;
			3'd3: oe = OP_XOR;
			3'd4: oe = OP_ADDI;
			3'd5, 3'd6: oe = OP_MPY;
			default: oe = OP_NOP;
		endcase
		case (3'(draw(3)))
			3'd0, 3'd1: oo = OP_ROTQBY;
			3'd2, 3'd3: oo = OP_IL;
			3'd4: oo = OP_BR;
			3'd5, 3'd6: oo = OP_BRZ;
			default: oo = OP_NOP;
		endcase
		rte = pool_addr(3'(draw(3)));
		do begin  // Odd slot stays clear of the even rt
			rto = (oo inside {OP_BR, OP_BRZ} && draw(1)) ? '0 : pool_addr(3'(draw(3)));
			rao = pool_addr(3'(draw(3)));
			rbo = pool_addr(3'(draw(3)));
		end while (rto == rte || rao == rte || rbo == rte);
		drive_pair(oe, rte, pool_addr(3'(draw(3))), pool_addr(3'(draw(3))), oo, rto, rao, rbo);
	endtask

	always @(negedge clk)
		if (!reset && branch_taken)
			taken_count++;

	initial begin
		lfsr_state = 32'h4765b1cb;
		reset = 1'b1;
		first_odd = 1'b0;
		pc = '0;
		op_even = OP_NOP;
		format_even = FMT_RR;
		unit_even = UNIT_FX1;
		rt_addr_even = '0;
		ra_even_addr = '0;
		rb_even_addr = '0;
		rc_even_addr = '0;
		reg_write_even = 1'b0;
		imm_even = '0;
		op_odd = OP_NOP;
		format_odd = FMT_RR;
		unit_odd = UNIT_PERM;
		rt_addr_odd = '0;
		ra_odd_addr = '0;
		rb_odd_addr = '0;
		reg_write_odd = 1'b0;
		imm_odd = '0;
		stall_cycles = 0;
		repeat (2) @(posedge clk);
		#1 reset = 1'b0;
		for (int k = 0; k < 8; k++)  // Fill the pool with immediates
			drive_pair(OP_NOP, '0, '0, '0, OP_IL, pool_addr(3'(k)), '0, '0);
		repeat (400) random_pair();
		for (int k = 0; k < 8; k++)  // Register 0 stays zero, so OR reads the value back
			drive_pair(OP_OR, pool_addr(3'(k)), pool_addr(3'(k)), '0, OP_NOP, '0, '0, '0);
		repeat (8) drive_pair(OP_NOP, '0, '0, '0, OP_NOP, '0, '0, '0);
		repeat (2) @(negedge clk);
		if (stall_cycles == 0) begin
			tb_errors++;
			$display("No stall was seen, the hazard path was never exercised");
		end
		if (taken_count == 0) begin
			tb_errors++;
			$display("No taken branch was seen");
		end
		if (kill_count == 0) begin
			tb_errors++;
			$display("No taken branch with first_odd high was seen");
		end
		total_errors = error_count + tb_errors + spu_pipes_inst.props_inst.assert_errors;
		summary = $sformatf("Checks %0d, errors %0d (checker %0d, assertions %0d, tb %0d)",
			check_count, total_errors, error_count, spu_pipes_inst.props_inst.assert_errors,
			tb_errors);
		$display("%s, stalls %0d, branches %0d, kills %0d", summary, stall_cycles,
			taken_count, kill_count);
		if (total_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		#((PAIRS + 20) * 8 * 8);  // Every pair stalls far less than eight cycles
		$display("Timeout: the run did not finish in the expected time");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- flist.f
+incdir+include
verilog/spu_isa_pkg.sv
verilog/spu_pipe_pkg.sv
verilog/spu_issue_if.sv
verilog/register_table.sv
verilog/operand_forward.sv
verilog/even_pipe.sv
verilog/odd_pipe.sv
verilog/spu_pipes.sv
tests/spu_pipes_props.sv
tests/spu_pipes_checker.sv
tests/spu_pipes_tb.sv

//--- Bender.yml
package:
  name: spu_pipes

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/spu_isa_pkg.sv
      - verilog/spu_pipe_pkg.sv
      - verilog/spu_issue_if.sv
      - verilog/register_table.sv
      - verilog/operand_forward.sv
      - verilog/even_pipe.sv
      - verilog/odd_pipe.sv
      - verilog/spu_pipes.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/spu_pipes_props.sv
      - tests/spu_pipes_checker.sv
      - tests/spu_pipes_tb.sv
